/* Bender.yml */
package:
  name: nestang_core

sources:
  - include_dirs:
      - include
    files:
      - hw/nestang_pkg.sv
      - hw/host_regs.sv
      - hw/autofire.sv
      - hw/pad_mapper.sv
      - hw/joypad_port.sv
      - hw/ce_sequencer.sv
      - hw/mem_arbiter.sv
      - hw/nestang_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/nestang_core_props.sv
      - tb/nestang_core_tb.sv

/* build.f */
+incdir+include
hw/nestang_pkg.sv
hw/host_regs.sv
hw/autofire.sv
hw/pad_mapper.sv
hw/joypad_port.sv
hw/ce_sequencer.sv
hw/mem_arbiter.sv
hw/nestang_core.sv
tb/nestang_core_props.sv
tb/nestang_core_tb.sv

/* hw/autofire.sv */
/*
 * autofire generator
 * square wave on fire while btn is held, low for the first half period
 */
`timescale 1ns/1ps
`include "nestang_macros.svh"

module autofire import nestang_pkg::*; #(
  parameter int HALF = `AUTOFIRE_HALF  // cycles per half period
) (
  input  logic clk,
  input  logic sys_resetn,
  input  logic btn,
  output logic fire
);

  localparam int CNT_W = $clog2(HALF + 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (!sys_resetn || !btn) begin
      cnt  <= '0;  // release restarts the wave
      fire <= 1'b0;
    end else if (cnt == CNT_W'(HALF - 1)) begin
      cnt  <= '0;
      fire <= !fire;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

/* hw/ce_sequencer.sv */
/*
 * clock-enable sequencer
 * five-phase counter, memory slot in phase 0 and nes slot in phase 4,
 * both held off until the loader is done
 */
`timescale 1ns/1ps
`include "nestang_macros.svh"

module ce_sequencer import nestang_pkg::*; (
  input  logic clk,
  input  logic sys_resetn,
  input  logic loader_done,
  output logic run_mem,
  output logic run_nes
);

  ce_phase_t phase;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      phase <= PH_CMD;
    end else if (phase == ce_phase_t'(`CE_PHASES - 1)) begin
      phase <= PH_CMD;
    end else begin
      phase <= ce_phase_t'(phase + 1'b1);
    end
  end

  // nes slot reads the data of the memory slot 4 cycles back
  assign run_mem = loader_done && phase == PH_CMD;
  assign run_nes = loader_done && phase == PH_NES;

endmodule

/* hw/host_regs.sv */
/*
 * host register demux
 * decodes uart register writes into loader config and host buttons,
 * and merges the uart rom bytes with the sd byte stream for the loader
 */
`timescale 1ns/1ps
`include "nestang_macros.svh"

module host_regs import nestang_pkg::*; (
  input  logic       clk,
  input  logic       sys_resetn,
  input  host_byte_t uart_addr,
  input  host_byte_t uart_data,
  input  logic       uart_write,
  input  host_byte_t sd_byte,
  input  logic       sd_valid,
  output host_byte_t loader_byte,
  output logic       loader_strobe,
  output logic       loader_reset,
  output nes_btn_t   host_btn1,
  output nes_btn_t   host_btn2
);

  logic conf_reset;  // only bit 0 of the config register has a meaning

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      conf_reset <= 1'b0;
      host_btn1  <= '0;
      host_btn2  <= '0;
    end else if (uart_write) begin
      if (uart_addr == `HOST_ADDR_CONF) conf_reset <= uart_data[0];
      if (uart_addr == `HOST_ADDR_PAD1) host_btn1 <= uart_data;
      if (uart_addr == `HOST_ADDR_PAD2) host_btn2 <= uart_data;
    end
  end

  // sd card stream wins over uart rom bytes
  assign loader_byte   = sd_valid ? sd_byte : uart_data;
  assign loader_strobe = (uart_write && uart_addr == `HOST_ADDR_ROM) || sd_valid;

  assign loader_reset = !sys_resetn || conf_reset;

endmodule

/* hw/joypad_port.sv */
/*
 * nes joypad port
 * parallel load while strobe is high, shift out lsb first on the
 * falling edge of the joypad clock
 */
`timescale 1ns/1ps

module joypad_port import nestang_pkg::*; (
  input  logic     clk,
  input  logic     sys_resetn,
  input  nes_btn_t pad_btn,
  input  logic     joypad_strobe,
  input  logic     joypad_clock,
  output logic     joypad_data
);

  nes_btn_t bits;
  logic     clock_q;   // last joypad clock level

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      bits    <= '0;
      clock_q <= 1'b0;
    end else begin
      clock_q <= joypad_clock;
      if (clock_q && !joypad_clock) begin
        bits <= {1'b0, bits[$bits(nes_btn_t)-1:1]};  // zeros after the eighth read
      end else if (joypad_strobe) begin
        bits <= pad_btn;
      end
    end
  end

  assign joypad_data = bits[0];

endmodule

/* hw/mem_arbiter.sv */
/*
 * memory request arbiter
 * loader writes take the bus at any time, nes requests only in the
 * memory slot, refresh fills idle slots
 */
`timescale 1ns/1ps

module mem_arbiter import nestang_pkg::*; (
  input  logic      run_mem,
  input  logic      nes_read_cpu,
  input  logic      nes_read_ppu,
  input  logic      nes_write,
  input  mem_addr_t nes_addr,
  input  mem_data_t nes_dout,
  input  logic      loader_write,
  input  logic      loader_refresh,
  input  mem_addr_t loader_addr,
  input  mem_data_t loader_data,
  output logic      mem_read_a,
  output logic      mem_read_b,
  output logic      mem_write,
  output logic      mem_refresh,
  output mem_addr_t mem_addr,
  output mem_data_t mem_din
);

  logic nes_req;

  assign nes_req = nes_read_cpu || nes_read_ppu || nes_write;

  assign mem_read_a = nes_read_cpu && run_mem;  // cpu port
  assign mem_read_b = nes_read_ppu && run_mem;  // ppu port
  assign mem_write  = (nes_write && run_mem) || loader_write;

  // idle memory slot, or loader asking for refresh between bytes
  assign mem_refresh = (run_mem && !nes_req && !loader_write) ||
                       (loader_refresh && !loader_write);

  assign mem_addr = loader_write ? loader_addr : nes_addr;
  assign mem_din  = loader_write ? loader_data : nes_dout;

endmodule

/* hw/nestang_core.sv */
/*
 * nestang glue core
 * host registers, controller mapping, joypad ports, clock-enable
 * sequencer and memory arbiter between the nes, loader and memory
 */
`timescale 1ns/1ps

module nestang_core import nestang_pkg::*; (
  input  logic       clk,
  input  logic       sys_resetn,
  // host link and sd stream
  input  host_byte_t uart_addr,
  input  host_byte_t uart_data,
  input  logic       uart_write,
  input  host_byte_t sd_byte,
  input  logic       sd_valid,
  input  logic       loader_done,
  // controllers
  input  ds_byte_t   ds1_rx0,
  input  ds_byte_t   ds1_rx1,
  input  ds_byte_t   ds2_rx0,
  input  ds_byte_t   ds2_rx1,
  input  nes_btn_t   usb1_btn,
  input  nes_btn_t   usb2_btn,
  input  logic       usb1_x,
  input  logic       usb1_y,
  input  logic       usb2_x,
  input  logic       usb2_y,
  input  logic       joypad_strobe,
  input  logic [1:0] joypad_clock,  // one per player
  // nes and loader memory requests
  input  logic       nes_read_cpu,
  input  logic       nes_read_ppu,
  input  logic       nes_write,
  input  mem_addr_t  nes_addr,
  input  mem_data_t  nes_dout,
  input  logic       loader_write,
  input  logic       loader_refresh,
  input  mem_addr_t  loader_addr,
  input  mem_data_t  loader_data,
  // outputs
  output host_byte_t loader_byte,
  output logic       loader_strobe,
  output logic       loader_reset,
  output logic       run_nes,
  output logic [1:0] joypad_data,
  output logic       mem_read_a,
  output logic       mem_read_b,
  output logic       mem_write,
  output logic       mem_refresh,
  output mem_addr_t  mem_addr,
  output mem_data_t  mem_din
);

  nes_btn_t host_btn1;
  nes_btn_t host_btn2;
  nes_btn_t pad_btn1;
  nes_btn_t pad_btn2;
  logic     run_mem;

  host_regs host_regs_i (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .uart_addr     (uart_addr),
    .uart_data     (uart_data),
    .uart_write    (uart_write),
    .sd_byte       (sd_byte),
    .sd_valid      (sd_valid),
    .loader_byte   (loader_byte),
    .loader_strobe (loader_strobe),
    .loader_reset  (loader_reset),
    .host_btn1     (host_btn1),
    .host_btn2     (host_btn2)
  );

  pad_mapper pad_mapper1_i (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .ds_rx0     (ds1_rx0),
    .ds_rx1     (ds1_rx1),
    .usb_btn    (usb1_btn),
    .usb_x      (usb1_x),
    .usb_y      (usb1_y),
    .host_btn   (host_btn1),
    .pad_btn    (pad_btn1)
  );

  pad_mapper pad_mapper2_i (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .ds_rx0     (ds2_rx0),
    .ds_rx1     (ds2_rx1),
    .usb_btn    (usb2_btn),
    .usb_x      (usb2_x),
    .usb_y      (usb2_y),
    .host_btn   (host_btn2),
    .pad_btn    (pad_btn2)
  );

  joypad_port joypad_port1_i (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .pad_btn       (pad_btn1),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock[0]),
    .joypad_data   (joypad_data[0])
  );

  joypad_port joypad_port2_i (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .pad_btn       (pad_btn2),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock[1]),
    .joypad_data   (joypad_data[1])
  );

  ce_sequencer ce_sequencer_i (
    .clk         (clk),
    .sys_resetn  (sys_resetn),
    .loader_done (loader_done),
    .run_mem     (run_mem),
    .run_nes     (run_nes)
  );

  mem_arbiter mem_arbiter_i (
    .run_mem        (run_mem),
    .nes_read_cpu   (nes_read_cpu),
    .nes_read_ppu   (nes_read_ppu),
    .nes_write      (nes_write),
    .nes_addr       (nes_addr),
    .nes_dout       (nes_dout),
    .loader_write   (loader_write),
    .loader_refresh (loader_refresh),
    .loader_addr    (loader_addr),
    .loader_data    (loader_data),
    .mem_read_a     (mem_read_a),
    .mem_read_b     (mem_read_b),
    .mem_write      (mem_write),
    .mem_refresh    (mem_refresh),
    .mem_addr       (mem_addr),
    .mem_din        (mem_din)
  );

endmodule

/* hw/nestang_pkg.sv */
/*
 * nestang core types
 * byte, button, memory vectors and the clock-enable phase encoding
 */
package nestang_pkg;

  `include "nestang_macros.svh"

  typedef logic [`BYTE_WIDTH-1:0] host_byte_t;     // uart address or data byte

  // R L D U START SELECT B A from msb down, 1 = pressed
  typedef logic [`BYTE_WIDTH-1:0] nes_btn_t;

  typedef logic [`BYTE_WIDTH-1:0] ds_byte_t;       // dualshock rx byte, active low

  typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;
  typedef logic [`BYTE_WIDTH-1:0] mem_data_t;

  // phase 0 issues the memory command, phase 4 clocks the nes
  typedef enum logic [$clog2(`CE_PHASES)-1:0] {
    PH_CMD,
    PH_ACTIVE,
    PH_RW,
    PH_WAIT,
    PH_NES
  } ce_phase_t;

endpackage

/* hw/pad_mapper.sv */
/*
 * per-player button mapper
 * dualshock bytes and usb gamepad bits to one nes button byte,
 * with autofire on square (B) and triangle (A)
 */
`timescale 1ns/1ps

module pad_mapper import nestang_pkg::*; (
  input  logic     clk,
  input  logic     sys_resetn,
  input  ds_byte_t ds_rx0,    // L D R U St R3 L3 Se
  input  ds_byte_t ds_rx1,    // sq X O tri R1 L1 R2 L2
  input  nes_btn_t usb_btn,
  input  logic     usb_x,
  input  logic     usb_y,
  input  nes_btn_t host_btn,
  output nes_btn_t pad_btn
);

  logic     sq_fire;
  logic     tri_fire;
  nes_btn_t ds_btn;

  autofire af_square (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .btn        (!ds_rx1[7] || usb_y),
    .fire       (sq_fire)
  );

  autofire af_triangle (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .btn        (!ds_rx1[4] || usb_x),
    .fire       (tri_fire)
  );

  // X is B, O is A
  assign ds_btn = {~ds_rx0[5], ~ds_rx0[7], ~ds_rx0[6], ~ds_rx0[4],
                   ~ds_rx0[3], ~ds_rx0[0],
                   ~ds_rx1[6] | sq_fire,
                   ~ds_rx1[5] | tri_fire};

  assign pad_btn = ds_btn | usb_btn | host_btn;

endmodule

/* include/nestang_macros.svh */
/*
 * nestang core constants
 * host register map, bus widths, sequencer length and autofire rate
 */
`ifndef NESTANG_MACROS_SVH
`define NESTANG_MACROS_SVH

// host register map on the uart link
`define HOST_ADDR_CONF 8'h35  // loader config, bit 0 holds the loader in reset
`define HOST_ADDR_ROM  8'h37  // rom data bytes for the loader
`define HOST_ADDR_PAD1 8'h40
`define HOST_ADDR_PAD2 8'h41

`define BYTE_WIDTH     8
`define MEM_ADDR_WIDTH 22     // 4MB address space

`define CE_PHASES      5      // memory slot plus nes slot per period

// cycles per autofire half period, kept small for simulation
`define AUTOFIRE_HALF  8

`endif

/* tb/nestang_core_props.sv */
/*
 * nestang core timing properties
 * slot order of the sequencer and loader write priority in the arbiter
 */
`timescale 1ns/1ps

module nestang_core_props (
  input logic clk,
  input logic sys_resetn,
  input logic loader_done,
  input logic run_mem,
  input logic run_nes,
  input logic loader_write,
  input logic mem_write
);

  // nes slot always comes 4 cycles after a memory slot
  a_nes_after_mem: assert property (@(posedge clk) disable iff (!sys_resetn)
    (run_nes && $past(loader_done, 4)) |-> $past(run_mem, 4))
    else $error("run_nes without run_mem four cycles earlier");

  a_slots_apart: assert property (@(posedge clk) disable iff (!sys_resetn)
    !(run_mem && run_nes))
    else $error("run_mem and run_nes high in the same cycle");

  a_held_off: assert property (@(posedge clk) disable iff (!sys_resetn)
    !loader_done |-> !run_mem && !run_nes)
    else $error("slot active while loader_done is low");

  a_loader_write: assert property (@(posedge clk) disable iff (!sys_resetn)
    loader_write |-> mem_write)
    else $error("loader_write not passed on to mem_write");

endmodule

bind nestang_core nestang_core_props props_i (
  .clk          (clk),
  .sys_resetn   (sys_resetn),
  .loader_done  (loader_done),
  .run_mem      (run_mem),
  .run_nes      (run_nes),
  .loader_write (loader_write),
  .mem_write    (mem_write)
);

/* tb/nestang_core_tb.sv */
/*
 * nestang core testbench
 * table of host writes, pad states and memory requests applied in a loop,
 * joypad readout, loader stream, slot timing and arbiter checks
 */
`timescale 1ns/1ps
`include "nestang_macros.svh"

module nestang_core_tb import nestang_pkg::*;;

  localparam int MAX_ROWS = 24;
  localparam int OP_PAD = 0;      // host button write, then joypad readout
  localparam int OP_MAP = 1;      // dualshock and usb mapping
  localparam int OP_FIRE = 2;     // autofire on square
  localparam int OP_ROM = 3;
  localparam int OP_SD = 4;
  localparam int OP_CONF = 5;
  localparam int OP_SLOT = 6;
  localparam int OP_ARB_LD = 7;
  localparam int OP_ARB_NES = 8;

  logic       clk;
  logic       sys_resetn;
  host_byte_t uart_addr;
  host_byte_t uart_data;
  logic       uart_write;
  host_byte_t sd_byte;
  logic       sd_valid;
  logic       loader_done;
  ds_byte_t   ds1_rx0;
  ds_byte_t   ds1_rx1;
  ds_byte_t   ds2_rx0;
  ds_byte_t   ds2_rx1;
  nes_btn_t   usb1_btn;
  nes_btn_t   usb2_btn;
  logic       usb1_x;
  logic       usb1_y;
  logic       usb2_x;
  logic       usb2_y;
  logic       joypad_strobe;
  logic [1:0] joypad_clock;
  logic       nes_read_cpu;
  logic       nes_read_ppu;
  logic       nes_write;
  mem_addr_t  nes_addr;
  mem_data_t  nes_dout;
  logic       loader_write;
  logic       loader_refresh;
  mem_addr_t  loader_addr;
  mem_data_t  loader_data;
  host_byte_t loader_byte;
  logic       loader_strobe;
  logic       loader_reset;
  logic       run_nes;
  logic [1:0] joypad_data;
  logic       mem_read_a;
  logic       mem_read_b;
  logic       mem_write;
  logic       mem_refresh;
  mem_addr_t  mem_addr;
  mem_data_t  mem_din;

  integer seed = 32'h2ff8_898a;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;
  int     cycle_limit = 100000;  // replaced once the table is built
  int     n_rows = 0;

  // stimulus table, one entry per row
  int         row_kind [MAX_ROWS];
  int         row_player [MAX_ROWS];
  host_byte_t row_addr [MAX_ROWS];
  host_byte_t row_data [MAX_ROWS];
  ds_byte_t   row_rx0 [MAX_ROWS];
  ds_byte_t   row_rx1 [MAX_ROWS];
  nes_btn_t   row_usb [MAX_ROWS];
  logic [7:0] row_exp [MAX_ROWS];

  nestang_core nestang_core_i (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic add_row(input int kind, input int player, input host_byte_t addr,
                         input host_byte_t data, input ds_byte_t rx0, input ds_byte_t rx1,
                         input nes_btn_t usb, input logic [7:0] exp);
    row_kind[n_rows]   = kind;
    row_player[n_rows] = player;
    row_addr[n_rows]   = addr;
    row_data[n_rows]   = data;
    row_rx0[n_rows]    = rx0;
    row_rx1[n_rows]    = rx1;
    row_usb[n_rows]    = usb;
    row_exp[n_rows]    = exp;
    n_rows++;
  endtask

  task automatic build_table();
    // kind       pl addr             data   rx0    rx1    usb    expected
    add_row(OP_PAD,     0, `HOST_ADDR_PAD1, 8'ha5, 8'hff, 8'hff, 8'h00, 8'ha5);
    add_row(OP_PAD,     1, `HOST_ADDR_PAD2, 8'h3c, 8'hff, 8'hff, 8'h00, 8'h3c);
    add_row(OP_PAD,     0, `HOST_ADDR_PAD1, 8'h01, 8'hff, 8'hff, 8'h00, 8'h01);
    add_row(OP_PAD,     1, `HOST_ADDR_PAD2, 8'h80, 8'hff, 8'hff, 8'h00, 8'h80);
    add_row(OP_MAP,     0, 8'h00,           8'h00, 8'hff, 8'hff, 8'h00, 8'h00);
    add_row(OP_MAP,     0, 8'h00,           8'h00, 8'hdf, 8'hff, 8'h00, 8'h80);  // R
    add_row(OP_MAP,     0, 8'h00,           8'h00, 8'h7e, 8'hbf, 8'h00, 8'h46);  // L SEL B
    add_row(OP_MAP,     1, 8'h00,           8'h00, 8'ha7, 8'hdf, 8'h80, 8'hb9);  // R D U ST A
    add_row(OP_MAP,     1, 8'h00,           8'h00, 8'hff, 8'hff, 8'h5a, 8'h5a);  // usb only
    add_row(OP_FIRE,    0, 8'h00,           8'h00, 8'hff, 8'h7f, 8'h00, 8'h02);  // square held
    add_row(OP_ROM,     0, `HOST_ADDR_ROM,  8'hc4, 8'hff, 8'hff, 8'h00, 8'hc4);
    add_row(OP_SD,      0, `HOST_ADDR_ROM,  8'h11, 8'hff, 8'hff, 8'h00, 8'h9e);  // exp is sd_byte
    add_row(OP_CONF,    0, `HOST_ADDR_CONF, 8'h01, 8'hff, 8'hff, 8'h00, 8'h01);
    add_row(OP_CONF,    0, `HOST_ADDR_CONF, 8'h00, 8'hff, 8'hff, 8'h00, 8'h00);
    add_row(OP_SLOT,    0, 8'h00,           8'h00, 8'hff, 8'hff, 8'h00, 8'd0);   // data is loader_done
    add_row(OP_SLOT,    0, 8'h00,           8'h01, 8'hff, 8'hff, 8'h00, 8'd8);
    add_row(OP_ARB_LD,  0, 8'h00,           8'h5b, 8'hff, 8'hff, 8'h00, 8'h5b);
    // data is {write, ppu, cpu}, exp is {refresh, write, read_b, read_a} in the slot
    add_row(OP_ARB_NES, 0, 8'h00,           8'h03, 8'hff, 8'hff, 8'h00, 8'h03);
    add_row(OP_ARB_NES, 0, 8'h00,           8'h00, 8'hff, 8'hff, 8'h00, 8'h08);
    add_row(OP_ARB_NES, 0, 8'h00,           8'h04, 8'hff, 8'hff, 8'h00, 8'h04);
  endtask

  task automatic host_write(input host_byte_t addr, input host_byte_t data);
    @(posedge clk);
    uart_addr  <= addr;
    uart_data  <= data;
    uart_write <= 1'b1;
    @(posedge clk);
    uart_write <= 1'b0;
    uart_data  <= $random(seed);  // idle noise
  endtask

  // player p gets the given pad state, the other player idles
  task automatic drive_pads(input int p, input ds_byte_t rx0, input ds_byte_t rx1,
                            input nes_btn_t usb);
    @(posedge clk);
    ds1_rx0  <= (p == 0) ? rx0 : 8'hff;
    ds1_rx1  <= (p == 0) ? rx1 : 8'hff;
    usb1_btn <= (p == 0) ? usb : 8'h00;
    ds2_rx0  <= (p == 1) ? rx0 : 8'hff;
    ds2_rx1  <= (p == 1) ? rx1 : 8'hff;
    usb2_btn <= (p == 1) ? usb : 8'h00;
  endtask

  task automatic strobe_pads();
    @(posedge clk);
    joypad_strobe <= 1'b1;
    @(posedge clk);
    joypad_strobe <= 1'b0;  // byte loaded at this edge
  endtask

  task automatic shift_pad(input int p);
    @(posedge clk);
    joypad_clock[p] <= 1'b1;
    @(posedge clk);
    joypad_clock[p] <= 1'b0;
    @(posedge clk);  // falling edge seen, register shifts here
  endtask

  task automatic read_pad(input int p, output nes_btn_t value, output logic tail);
    strobe_pads();
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      value[i] = joypad_data[p];
      shift_pad(p);
    end
    @(negedge clk);
    tail = joypad_data[p];
  endtask

  task automatic apply_row(input int r);
    int         p;
    nes_btn_t   value;
    logic       tail;
    logic       seen0;
    logic       seen1;
    int         pulses;
    int         last;
    mem_addr_t  laddr;
    logic [3:0] slot_out [20];
    logic       slot_nes [20];
    p = row_player[r];
    case (row_kind[r])
      OP_PAD: begin
        drive_pads(p, 8'hff, 8'hff, 8'h00);
        host_write(row_addr[r], row_data[r]);
        read_pad(p, value, tail);
        check_val("joypad_data byte", value, row_exp[r]);
        check_val("joypad_data after 8 reads", tail, 0);
      end
      OP_MAP: begin
        host_write((p == 0) ? `HOST_ADDR_PAD1 : `HOST_ADDR_PAD2, 8'h00);
        drive_pads(p, row_rx0[r], row_rx1[r], row_usb[r]);
        read_pad(p, value, tail);
        check_val("mapped joypad byte", value, row_exp[r]);
      end
      OP_FIRE: begin
        drive_pads(p, row_rx0[r], row_rx1[r], row_usb[r]);
        seen0 = 1'b0;
        seen1 = 1'b0;
        for (int k = 0; k < 6; k++) begin
          strobe_pads();  // loads land exactly one half period apart
          shift_pad(p);
          @(negedge clk);
          if ((joypad_data[p] & row_exp[r][1]) != 0) seen1 = 1'b1;
          else seen0 = 1'b1;
          repeat (`AUTOFIRE_HALF - 5) @(posedge clk);
        end
        if (!(seen0 && seen1)) begin
          errors++;
          $display("autofire on player %0d did not toggle button B", p + 1);
        end
        drive_pads(p, 8'hff, 8'hff, 8'h00);
        read_pad(p, value, tail);
        check_val("button B after release", value[1], 0);
      end
      OP_ROM, OP_SD: begin
        @(posedge clk);
        uart_addr  <= row_addr[r];
        uart_data  <= row_data[r];
        uart_write <= 1'b1;
        sd_valid   <= (row_kind[r] == OP_SD);
        sd_byte    <= (row_kind[r] == OP_SD) ? row_exp[r] : 8'h00;
        @(negedge clk);
        check_val("loader_strobe", loader_strobe, 1);
        check_val("loader_byte", loader_byte, row_exp[r]);
        @(posedge clk);
        uart_write <= 1'b0;
        sd_valid   <= 1'b0;
        sd_byte    <= $random(seed);
        @(negedge clk);
        check_val("loader_strobe idle", loader_strobe, 0);
      end
      OP_CONF: begin
        host_write(row_addr[r], row_data[r]);
        @(negedge clk);
        check_val("loader_reset", loader_reset, row_exp[r]);
      end
      OP_SLOT: begin
        @(posedge clk);
        loader_done <= row_data[r][0];
        @(posedge clk);
        pulses = 0;
        last   = -1;
        for (int c = 0; c < 40; c++) begin
          @(negedge clk);
          if (run_nes) begin
            if (last >= 0) check_val("run_nes period", c - last, 5);
            last = c;
            pulses++;
          end
        end
        check_val("run_nes pulses in 40 cycles", pulses, row_exp[r]);
      end
      OP_ARB_LD: begin
        laddr = $random(seed);
        @(posedge clk);
        loader_done    <= 1'b1;
        loader_write   <= 1'b1;
        loader_refresh <= 1'b1;  // refresh request yields to the write
        loader_addr    <= laddr;
        loader_data    <= row_data[r];
        nes_read_cpu   <= 1'b1;  // pending nes request must lose the bus
        nes_addr       <= $random(seed);
        nes_dout       <= $random(seed);
        for (int c = 0; c < 5; c++) begin  // one pass over every phase
          @(negedge clk);
          check_val("mem_write", mem_write, 1);
          check_val("mem_addr", mem_addr, laddr);
          check_val("mem_din", mem_din, row_exp[r]);
          check_val("mem_refresh", mem_refresh, 0);
        end
        @(posedge clk);
        loader_write   <= 1'b0;
        loader_refresh <= 1'b0;
        nes_read_cpu   <= 1'b0;
      end
      OP_ARB_NES: begin
        @(posedge clk);
        loader_done  <= 1'b1;
        nes_read_cpu <= row_data[r][0];
        nes_read_ppu <= row_data[r][1];
        nes_write    <= row_data[r][2];
        for (int c = 0; c < 20; c++) begin
          @(negedge clk);
          slot_out[c] = {mem_refresh, mem_write, mem_read_b, mem_read_a};
          slot_nes[c] = run_nes;
        end
        // the memory slot sits 4 cycles ahead of each nes slot
        for (int c = 0; c < 16; c++) begin
          check_val("mem refresh/write/read_b/read_a", slot_out[c],
                    slot_nes[c + 4] ? row_exp[r] : 4'b0000);
        end
        @(posedge clk);
        nes_read_cpu <= 1'b0;
        nes_read_ppu <= 1'b0;
        nes_write    <= 1'b0;
      end
      default: begin
        errors++;
        $display("row %0d has an unknown operation kind", r);
      end
    endcase
  endtask

  initial begin
    sys_resetn     = 1'b0;
    uart_addr      = 8'h00;
    uart_data      = 8'h00;
    uart_write     = 1'b0;
    sd_byte        = $random(seed);
    sd_valid       = 1'b0;
    loader_done    = 1'b0;
    ds1_rx0        = 8'hff;  // active low, all released
    ds1_rx1        = 8'hff;
    ds2_rx0        = 8'hff;
    ds2_rx1        = 8'hff;
    usb1_btn       = 8'h00;
    usb2_btn       = 8'h00;
    usb1_x         = 1'b0;
    usb1_y         = 1'b0;
    usb2_x         = 1'b0;
    usb2_y         = 1'b0;
    joypad_strobe  = 1'b0;
    joypad_clock   = 2'b00;
    nes_read_cpu   = 1'b0;
    nes_read_ppu   = 1'b0;
    nes_write      = 1'b0;
    nes_addr       = $random(seed);
    nes_dout       = $random(seed);
    loader_write   = 1'b0;
    loader_refresh = 1'b0;
    loader_addr    = $random(seed);
    loader_data    = $random(seed);
    build_table();
    cycle_limit = n_rows * 40 + 200;
    repeat (4) @(posedge clk);
    sys_resetn <= 1'b1;
    @(posedge clk);
    for (int r = 0; r < n_rows; r++) apply_row(r);
    repeat (2) @(posedge clk);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule
